//--- src.f
+incdir+common
common/fadd_pkg.sv
common/fadd_stage_if.sv
verilog/count_leading_zeros.sv
fadd/fadd_compare_stage.sv
fadd/fadd_align_stage.sv
fadd/fadd_sum_stage.sv
fadd/fadd_normalize_stage.sv
fadd/fadd_top.sv
test/tb_clock_gen.sv
test/tb_fadd_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the floating-point adder testbench with Verilator and runs it
# The result is taken from the testbench output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
        -f src.f --top-module tb_fadd_top; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_fadd_top 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_output"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

//--- test/tb_fadd_top.sv
//============================================================
// Testbench for the pipelined floating-point adder
// Random operands, stalls and flushes checked against a
// cycle model of the four-stage pipeline
//============================================================

`default_nettype none

`include "fadd_macros.svh"

module tb_fadd_top;
    timeunit 1ns;
    timeprecision 100ps;

    import fadd_pkg::*;

    localparam int period_ns    = 100;
    localparam int reset_cycles = 10;
    localparam int num_items    = 400;
    // Roughly two cycles per item are needed and four leave plenty of room
    localparam int timeout_ns   = (reset_cycles + 4 * num_items + 100) * period_ns;

    // Expected output of one accepted item and the advance count at which it shows up
    typedef struct packed {
        logic [31:0] result;
        logic        invalid;
        logic        overflow;
        logic        underflow;
        logic [31:0] due;
    } expect_t;

    logic     clk, rst_n, stall, flush, in_valid;
    float_t   op_a, op_b, res;
    fadd_op_e op_sel;
    logic     out_valid, out_invalid, out_overflow, out_underflow;

    expect_t     expect_q[$];
    int unsigned adv_count;
    int          accepted, checked, flushed, error_count;
    int          ovf_seen, unf_seen, nan_seen, inf_seen;
    logic        last_hold, prev_valid;
    float_t      prev_result;

    tb_clock_gen #(.period_ns(period_ns)) u_clk (.clk_o(clk));

    fadd_top uut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .stall_i     (stall),
        .flush_i     (flush),
        .valid_i     (in_valid),
        .operand_a_i (op_a),
        .operand_b_i (op_b),
        .op_i        (op_sel),
        .result_o    (res),
        .valid_o     (out_valid),
        .invalid_o   (out_invalid),
        .overflow_o  (out_overflow),
        .underflow_o (out_underflow)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    //============================================================
    // Reference model giving one result per operand pair
    //============================================================

    function automatic expect_t model_item(input logic [31:0] a, input logic [31:0] b,
                                           input logic sub);
        logic    sa, sb, smaj, smin, a_inf, a_nan, b_inf, b_nan, a_major, ovf, unf;
        int      ea, eb, emaj, emin, full_maj, full_min, aligned, s, e, lz;
        expect_t item;
        sa    = a[31];
        sb    = b[31] ^ sub;
        ea    = int'(a[30:23]);
        eb    = int'(b[30:23]);
        a_inf = (ea == 255) && (a[22:0] == '0);
        a_nan = (ea == 255) && (a[22:0] != '0);
        b_inf = (eb == 255) && (b[22:0] == '0);
        b_nan = (eb == 255) && (b[22:0] != '0);
        // Larger magnitude goes first and A keeps ties
        a_major  = (ea > eb) || ((ea == eb) && (a[22:0] >= b[22:0]));
        smaj     = a_major ? sa : sb;
        smin     = a_major ? sb : sa;
        emaj     = a_major ? ea : eb;
        emin     = a_major ? eb : ea;
        full_maj = int'(a_major ? a[22:0] : b[22:0]) + ((emaj != 0) ? 'h800000 : 0);
        full_min = int'(a_major ? b[22:0] : a[22:0]) + ((emin != 0) ? 'h800000 : 0);
        aligned  = (emaj - emin >= 24) ? 0 : (full_min >> (emaj - emin));
        s        = (smaj == smin) ? full_maj + aligned : full_maj - aligned;
        e        = emaj;
        ovf      = 1'b0;
        unf      = 1'b0;
        if (s >= 'h1000000) begin
            s = s >> 1;
            if (e == int'(`FADD_MAX_EXP)) begin
                ovf = 1'b1;
            end else begin
                e = e + 1;
            end
        end else begin
            // Count leading zeros of the 24-bit significand, giving 24 for a zero sum
            lz = 0;
            while ((lz < 24) && (s < ('h800000 >> lz))) begin
                lz++;
            end
            if (e - lz >= 1) begin
                s = s << lz;
                e = e - lz;
            end else begin
                s   = s << (e - 1);
                e   = 0;
                unf = 1'b1;
            end
        end
        item.result    = {smaj, 8'(e), 23'(s)};
        item.invalid   = a_nan || b_nan || (a_inf && b_inf && (sa != sb));
        item.overflow  = ovf;
        item.underflow = unf;
        item.due       = '0;
        if (item.invalid) begin
            item.result    = `FADD_CANON_NAN;
            item.overflow  = 1'b0;
            item.underflow = 1'b0;
        end else if (a_inf || b_inf) begin
            item.result    = {smaj, 8'hFF, 23'h0};
            item.overflow  = ~smaj;
            item.underflow = smaj;
        end
        return item;
    endfunction

    // Picks one of several operand classes, each aimed at a part of the datapath
    task automatic gen_operands(output logic [31:0] a, output logic [31:0] b,
                                output logic sub);
        int unsigned kind, ea, eb;
        logic [22:0] ma, mb;
        logic        sa, sb;
        logic [31:0] tmp;
        kind = $urandom_range(9);
        sub  = 1'($urandom_range(1));
        sa   = 1'($urandom_range(1));
        ma   = 23'($urandom);
        mb   = 23'($urandom);
        ea   = $urandom_range(240, 1);
        eb   = $urandom_range(240, 1);
        // Same effective sign unless a class below changes it
        sb   = sa ^ sub;
        case (kind)
            0: ;
            // Close exponents make the carry common
            1, 2: eb = ea + $urandom_range(2);
            3: begin
                sb = ~sb;
                eb = ea + $urandom_range(1);
            end
            // Near-equal magnitudes cancel and small exponents then underflow
            4, 5: begin
                sb = ~sb;
                ea = (kind == 5) ? $urandom_range(12, 1) : ea;
                eb = ea;
                mb = ma ^ (23'($urandom) & 23'h0000FF);
            end
            6: begin
                ea = 254;
                eb = $urandom_range(254, 252);
            end
            7: begin
                ea = 255;
                ma = ma | 23'h1;
            end
            8: begin
                ea = 255;
                ma = '0;
                if ($urandom_range(1) == 1) begin
                    eb = 255;
                    mb = '0;
                    sb = 1'($urandom_range(1));
                end
            end
            default: begin
                ea = $urandom_range(254, 1);
                eb = $urandom_range(254, 1);
                sb = 1'($urandom_range(1));
            end
        endcase
        a = {sa, 8'(ea), ma};
        b = {sb, 8'(eb), mb};
        // Special operand on either side
        if ((kind >= 7) && ($urandom_range(1) == 1)) begin
            tmp = a;
            a   = b;
            b   = tmp;
        end
    endtask

    //============================================================
    // Pipeline bookkeeping and output checks
    //============================================================

    // Applies the inputs seen at this rising edge to the expected queue
    task automatic advance_model();
        expect_t item;
        logic    front_shown;
        front_shown = (expect_q.size() > 0) && (expect_q[0].due == adv_count);
        last_hold   = stall && !flush;
        if (flush) begin
            // The item already checked at the output is not counted as lost
            flushed += expect_q.size() - int'(front_shown);
            expect_q.delete();
        end else if (!stall) begin
            if (front_shown) begin
                void'(expect_q.pop_front());
            end
            adv_count++;
            if (in_valid) begin
                item     = model_item(op_a, op_b, op_sel == FSUB);
                item.due = adv_count + `FADD_STAGES - 1;
                expect_q.push_back(item);
                accepted++;
            end
        end
    endtask

    task automatic check_outputs();
        expect_t front;
        logic    shown;
        shown = (expect_q.size() > 0) && (expect_q[0].due == adv_count);
        check_value(32'(out_valid), 32'(shown), "valid_o");
        if (last_hold) begin
            check_value(32'(out_valid), 32'(prev_valid), "valid_o across stall");
            if (prev_valid) begin
                check_value(res, prev_result, "result_o across stall");
            end
        end
        if (shown) begin
            front = expect_q[0];
            check_value(res, front.result, "result_o");
            check_value(32'(out_invalid), 32'(front.invalid), "invalid_o");
            check_value(32'(out_overflow), 32'(front.overflow), "overflow_o");
            check_value(32'(out_underflow), 32'(front.underflow), "underflow_o");
            // A held item is counted once
            if (!last_hold) begin
                checked++;
                ovf_seen += int'(front.overflow && (front.result[30:23] != 8'hFF));
                unf_seen += int'(front.underflow && (front.result[30:23] != 8'hFF));
                nan_seen += int'(front.invalid);
                inf_seen += int'(!front.invalid && (front.result[30:23] == 8'hFF));
            end
        end
        prev_valid  = out_valid;
        prev_result = res;
    endtask

    // Inputs change 1 ns after the edge and outputs are sampled at the falling edge
    task automatic run_cycle(input logic random_drive);
        logic [31:0] a, b;
        logic        sub;
        @(posedge clk);
        advance_model();
        #1;
        gen_operands(a, b, sub);
        op_a     = a;
        op_b     = b;
        op_sel   = sub ? FSUB : FADD;
        in_valid = random_drive && ($urandom_range(4) != 0);
        stall    = random_drive && ($urandom_range(7) == 0);
        flush    = random_drive && ($urandom_range(39) == 0);
        @(negedge clk);
        check_outputs();
    endtask

    //============================================================
    // Main sequence and watchdog
    //============================================================

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        op_a        = '0;
        op_b        = '0;
        op_sel      = FADD;
        adv_count   = 0;
        accepted    = 0;
        checked     = 0;
        flushed     = 0;
        error_count = 0;
        ovf_seen    = 0;
        unf_seen    = 0;
        nan_seen    = 0;
        inf_seen    = 0;
        last_hold   = 1'b0;
        prev_valid  = 1'b0;
        prev_result = '0;
        void'($urandom(32'h7441));

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        while (accepted < num_items) begin
            run_cycle(1'b1);
        end
        // Drain with quiet inputs, then confirm the output goes idle
        while (expect_q.size() > 0) begin
            run_cycle(1'b0);
        end
        repeat (2) run_cycle(1'b0);

        check_value(checked + flushed, accepted, "checked plus flushed item count");
        check_value(32'(ovf_seen > 0), 32'd1, "overflow results seen");
        check_value(32'(unf_seen > 0), 32'd1, "underflow results seen");
        check_value(32'(nan_seen > 0), 32'd1, "invalid results seen");
        check_value(32'(inf_seen > 0), 32'd1, "infinity results seen");

        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("ERRORS FOUND");
        $fatal(1, "timeout: the run did not finish within %0d ns", timeout_ns);
    end

endmodule : tb_fadd_top

`default_nettype wire

//--- test/tb_clock_gen.sv
//============================================================
// Testbench clock source
// Free-running clock, low at time zero
//============================================================

`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Half a period per level
    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2) clk_o = ~clk_o;
        end
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- fadd/fadd_top.sv
//============================================================
// Pipelined single-precision adder/subtractor
// Four stages, one operand pair per cycle, truncated result
//============================================================

`default_nettype none

module fadd_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic               flush_i,
    input  logic               valid_i,
    input  fadd_pkg::float_t   operand_a_i,
    input  fadd_pkg::float_t   operand_b_i,
    input  fadd_pkg::fadd_op_e op_i,
    output fadd_pkg::float_t   result_o,
    output logic               valid_o,
    output logic               invalid_o,
    output logic               overflow_o,
    output logic               underflow_o
);

    import fadd_pkg::*;

    // One link per stage boundary, each with its own payload
    fadd_stage_if #(.payload_t(cmp_payload_t))   cmp_link ();
    fadd_stage_if #(.payload_t(align_payload_t)) align_link ();
    fadd_stage_if #(.payload_t(sum_payload_t))   sum_link ();

    fadd_compare_stage u_compare (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .out_o       (cmp_link.src)
    );

    fadd_align_stage u_align (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .in_i    (cmp_link.dst),
        .out_o   (align_link.src)
    );

    fadd_sum_stage u_sum (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .in_i    (align_link.dst),
        .out_o   (sum_link.src)
    );

    // Last stage drives the outside result and flags directly
    fadd_normalize_stage u_normalize (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .in_i        (sum_link.dst),
        .result_o    (result_o),
        .valid_o     (valid_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule : fadd_top

`default_nettype wire

//--- fadd/fadd_normalize_stage.sv
//============================================================
// Adder stage 3: normalization and special cases
// Renormalizes the sum, registers it and then overrides it
// for NaN and infinity operands
//============================================================

`default_nettype none

`include "fadd_macros.svh"

module fadd_normalize_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    fadd_stage_if.dst        in_i,
    output fadd_pkg::float_t result_o,
    output logic             valid_o,
    output logic             invalid_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    import fadd_pkg::*;

    logic [`FADD_MAN_W:0]   sig_in;
    logic [`FADD_MAN_W:0]   sig_norm;
    logic [4:0]             lz_count;
    logic [`FADD_EXP_W:0]   exp_minus_lz;
    logic [`FADD_EXP_W-1:0] exp_in;
    logic [`FADD_EXP_W-1:0] exp_norm;
    logic                   ovf_next, unf_next;

    float_t result_q;
    logic   valid_q, invalid_q, infinity_q, ovf_q, unf_q;

    assign sig_in = {in_i.data.hidden, in_i.data.result.significand};
    assign exp_in = in_i.data.result.exponent;

    count_leading_zeros #(
        .width (24)
    ) u_clz (
        .operand_i  (sig_in),
        .lz_count_o (lz_count)
    );

    // Top bit set means the exponent would drop below the normal range
    assign exp_minus_lz = {1'b0, exp_in} - 9'(lz_count);

    //============================================================
    // Normalization
    //============================================================

    always_comb begin
        sig_norm = sig_in;
        exp_norm = exp_in;
        ovf_next = 1'b0;
        unf_next = 1'b0;
        if (in_i.data.carry) begin
            // Carry becomes the new hidden bit
            sig_norm = {1'b1, sig_in[`FADD_MAN_W:1]};
            if (exp_in == `FADD_MAX_EXP) begin
                ovf_next = 1'b1;
            end else begin
                exp_norm = exp_in + 8'd1;
            end
        end else if (!exp_minus_lz[`FADD_EXP_W] && (exp_minus_lz != '0)) begin
            sig_norm = sig_in << lz_count;
            exp_norm = exp_minus_lz[`FADD_EXP_W-1:0];
        end else begin
            // Only shift as far as the smallest normal exponent allows
            sig_norm = sig_in << (exp_in - `FADD_MIN_EXP);
            exp_norm = '0;
            unf_next = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= in_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            result_q   <= '{sign: in_i.data.result.sign, exponent: exp_norm,
                            significand: sig_norm[`FADD_MAN_W-1:0]};
            ovf_q      <= ovf_next;
            unf_q      <= unf_next;
            invalid_q  <= in_i.invalid_op;
            infinity_q <= in_i.infinity;
        end
    end

    //============================================================
    // Special-case output step
    //============================================================

    always_comb begin
        if (invalid_q) begin
            result_o    = `FADD_CANON_NAN;
            overflow_o  = 1'b0;
            underflow_o = 1'b0;
        end else if (infinity_q) begin
            // Infinity keeps the major sign, flags follow that sign
            result_o    = '{sign: result_q.sign, exponent: '1, significand: '0};
            overflow_o  = ~result_q.sign;
            underflow_o = result_q.sign;
        end else begin
            result_o    = result_q;
            overflow_o  = ovf_q;
            underflow_o = unf_q;
        end
    end

    assign valid_o   = valid_q;
    assign invalid_o = invalid_q;

    invalid_excludes_range : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && invalid_o) |-> !(overflow_o || underflow_o)
    );

endmodule : fadd_normalize_stage

`default_nettype wire

//--- fadd/fadd_sum_stage.sv
//============================================================
// Adder stage 2: significand add
// Adds or subtracts the aligned significands and flags carry
//============================================================

`default_nettype none

`include "fadd_macros.svh"

module fadd_sum_stage (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    fadd_stage_if.dst in_i,
    fadd_stage_if.src out_o
);

    import fadd_pkg::*;

    logic [`FADD_MAN_W:0]   major_full;
    logic [`FADD_MAN_W+1:0] sum;
    logic                   same_sign;
    sum_payload_t           payload;

    // Zero exponent means a subnormal major, so no hidden bit
    assign major_full = {in_i.data.major.exponent != '0, in_i.data.major.significand};
    assign same_sign  = (in_i.data.major.sign == in_i.data.minor_sign);

    // With different signs the major is at least as large as the minor,
    // so the difference is already its own absolute value
    always_comb begin
        if (same_sign) begin
            sum = {1'b0, major_full} + {1'b0, in_i.data.minor_aligned};
        end else begin
            sum = {1'b0, major_full - in_i.data.minor_aligned};
        end
    end

    // Sign and exponent come from the major operand
    assign payload.result.sign        = in_i.data.major.sign;
    assign payload.result.exponent    = in_i.data.major.exponent;
    assign payload.result.significand = sum[`FADD_MAN_W-1:0];
    assign payload.hidden             = sum[`FADD_MAN_W];
    assign payload.carry              = sum[`FADD_MAN_W+1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            out_o.valid <= 1'b0;
        end else if (!stall_i) begin
            out_o.valid <= in_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            out_o.data       <= payload;
            out_o.invalid_op <= in_i.invalid_op;
            out_o.infinity   <= in_i.infinity;
        end
    end

endmodule : fadd_sum_stage

`default_nettype wire

//--- fadd/fadd_align_stage.sv
//============================================================
// Adder stage 1: significand alignment
// Shifts the minor significand to the major exponent
//============================================================

`default_nettype none

`include "fadd_macros.svh"

module fadd_align_stage (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    fadd_stage_if.dst in_i,
    fadd_stage_if.src out_o
);

    import fadd_pkg::*;

    logic [`FADD_MAN_W:0] minor_full;
    align_payload_t       payload;

    // Restore the hidden bit in front of the stored significand
    assign minor_full = {in_i.data.minor_hidden, in_i.data.minor_significand};

    assign payload.major      = in_i.data.major;
    assign payload.minor_sign = in_i.data.minor_sign;
    // Bits shifted past the bottom are lost, the result is truncated
    assign payload.minor_aligned = (in_i.data.exp_diff >= 8'd24) ? '0 :
                                   (minor_full >> in_i.data.exp_diff);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            out_o.valid <= 1'b0;
        end else if (!stall_i) begin
            out_o.valid <= in_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            out_o.data       <= payload;
            out_o.invalid_op <= in_i.invalid_op;
            out_o.infinity   <= in_i.infinity;
        end
    end

endmodule : fadd_align_stage

`default_nettype wire

//--- fadd/fadd_compare_stage.sv
//============================================================
// Adder stage 0: operand compare
// Classifies operands, applies the subtract sign flip and
// orders the pair by magnitude
//============================================================

`default_nettype none

module fadd_compare_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  fadd_pkg::float_t  operand_a_i,
    input  fadd_pkg::float_t  operand_b_i,
    input  fadd_pkg::fadd_op_e op_i,
    fadd_stage_if.src         out_o
);

    import fadd_pkg::*;

    float_t       b_eff;
    float_t       major;
    float_t       minor;
    logic         a_is_major;
    logic         a_inf, a_nan, b_inf, b_nan;
    cmp_payload_t payload;

    // Subtraction is an add with B negated
    assign b_eff = '{sign: (op_i == FSUB) ? ~operand_b_i.sign : operand_b_i.sign,
                     exponent: operand_b_i.exponent,
                     significand: operand_b_i.significand};

    // All-ones exponent marks infinity or NaN depending on the significand
    assign a_inf = (&operand_a_i.exponent) && (operand_a_i.significand == '0);
    assign a_nan = (&operand_a_i.exponent) && (operand_a_i.significand != '0);
    assign b_inf = (&operand_b_i.exponent) && (operand_b_i.significand == '0);
    assign b_nan = (&operand_b_i.exponent) && (operand_b_i.significand != '0);

    // A wins on equal exponents and equal significands
    assign a_is_major = (operand_a_i.exponent > operand_b_i.exponent) ||
                        ((operand_a_i.exponent == operand_b_i.exponent) &&
                         (operand_a_i.significand >= operand_b_i.significand));

    assign major = a_is_major ? operand_a_i : b_eff;
    assign minor = a_is_major ? b_eff : operand_a_i;

    assign payload.major             = major;
    assign payload.minor_sign        = minor.sign;
    assign payload.minor_hidden      = (minor.exponent != '0);
    assign payload.minor_significand = minor.significand;
    // Never negative because of the ordering above
    assign payload.exp_diff          = major.exponent - minor.exponent;

    //============================================================
    // Stage register
    //============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            out_o.valid <= 1'b0;
        end else if (!stall_i) begin
            out_o.valid <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            out_o.data       <= payload;
            // Opposite infinities cancel to an undefined value
            out_o.invalid_op <= a_nan || b_nan ||
                                (a_inf && b_inf && (operand_a_i.sign ^ b_eff.sign));
            out_o.infinity   <= a_inf || b_inf;
        end
    end

    // A stall holds the whole pipeline, valid bits included
    stall_holds_valid : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> $stable(out_o.valid)
    );

endmodule : fadd_compare_stage

`default_nettype wire

//--- verilog/count_leading_zeros.sv
//============================================================
// Leading-zero counter
// Priority encoder from the most significant bit
//============================================================

`default_nettype none

module count_leading_zeros #(
    parameter int width = 24
) (
    input  logic [width-1:0]             operand_i,
    output logic [$clog2(width+1)-1:0]   lz_count_o
);

    localparam int cnt_w = $clog2(width + 1);

    // Scan upward so the highest set bit is the last one to win,
    // an all-zero operand keeps the full width
    always_comb begin
        lz_count_o = cnt_w'(width);
        for (int i = 0; i < width; i++) begin
            if (operand_i[i]) begin
                lz_count_o = cnt_w'(width - 1 - i);
            end
        end
    end

endmodule : count_leading_zeros

`default_nettype wire

//--- common/fadd_stage_if.sv
//============================================================
// Link between two adder pipeline stages
// Payload type is set per link by a type parameter
//============================================================

`default_nettype none

interface fadd_stage_if #(
    parameter type payload_t = logic
) ();

    // Item in the stage register is real
    logic     valid;
    payload_t data;
    // Exception state carried alongside the payload
    logic     invalid_op;
    logic     infinity;

    modport src (output valid, data, invalid_op, infinity);
    modport dst (input valid, data, invalid_op, infinity);

endinterface : fadd_stage_if

`default_nettype wire

//--- common/fadd_pkg.sv
//============================================================
// Floating-point adder types
// Operand format, operation code and stage payloads
//============================================================

`default_nettype none

`include "fadd_macros.svh"

package fadd_pkg;

    // Binary32 layout, sign in the top bit
    typedef struct packed {
        logic                   sign;
        logic [`FADD_EXP_W-1:0] exponent;
        logic [`FADD_MAN_W-1:0] significand;
    } float_t;

    // FSUB flips the sign of operand B before the add
    typedef enum logic {
        FADD = 1'b0,
        FSUB = 1'b1
    } fadd_op_e;

    // Compare stage output: ordered operands and the shift distance
    typedef struct packed {
        float_t                 major;
        logic                   minor_sign;
        logic                   minor_hidden;
        logic [`FADD_MAN_W-1:0] minor_significand;
        logic [`FADD_EXP_W-1:0] exp_diff;
    } cmp_payload_t;

    // Align stage output, the minor significand now includes its hidden bit
    typedef struct packed {
        float_t               major;
        logic                 minor_sign;
        logic [`FADD_MAN_W:0] minor_aligned;
    } align_payload_t;

    // Sum stage output, still to be normalized
    typedef struct packed {
        float_t result;
        logic   hidden;
        logic   carry;
    } sum_payload_t;

endpackage : fadd_pkg

`default_nettype wire

//--- common/fadd_macros.svh
//============================================================
// Single-precision adder constants
// Field widths, pipeline depth and the special encodings
//============================================================

`ifndef FADD_MACROS_SVH
`define FADD_MACROS_SVH

// IEEE 754 binary32 field widths
`define FADD_EXP_W 8
`define FADD_MAN_W 23

// Number of register stages between operands and result
`define FADD_STAGES 4

// Biased exponent limits for normal numbers
`define FADD_MAX_EXP 8'd254
`define FADD_MIN_EXP 8'd1

`define FADD_CANON_NAN 32'h7FC00000

`endif
